//--- hdl/cmd_deser.sv
`default_nettype none
`include "pio_config.svh"

module cmd_deser import pio_pkg::*; (
    input  logic       mclk,
    input  logic       mrst,
    input  logic [7:0] ad,     // AL, AH, D0..D3
    input  logic       stb,    // with the first byte only
    output logic       wr_stb, // one cycle after the sixth byte
    output ser_cmd_t   wr
);

    logic [2:0]  cnt; // bytes received so far, 0 when idle
    logic [47:0] sr;
    logic [47:0] sr_nxt;
    logic        addr_hit;

    assign sr_nxt   = {ad, sr[47:8]}; // bytes enter from the top, LSB first
    assign addr_hit = ((sr_nxt[15:0] ^ `PIO_BASE_ADDR) & `PIO_ADDR_MASK) == 16'h0;

    always_ff @(posedge mclk) begin
        if (mrst) begin
            cnt <= 3'd0;
        end else if (stb) begin
            cnt <= 3'd1;
        end else if (cnt == 3'd5) begin
            cnt <= 3'd0; // sixth byte in
        end else if (cnt != 3'd0) begin
            cnt <= cnt + 3'd1;
        end

        if (mrst) begin
            wr_stb <= 1'b0;
        end else begin
            wr_stb <= (cnt == 3'd5) && addr_hit;
        end
    end

    always_ff @(posedge mclk) begin
        if (stb || (cnt != 3'd0)) begin
            sr <= sr_nxt;
        end
    end

    assign wr.reg_idx = sr[4:0];   // low address bits pick the register
    assign wr.data    = sr[47:16];

    // host must finish a six-byte sequence before starting another
    assert property (@(posedge mclk) disable iff (mrst) stb |-> (cnt == 3'd0))
        else $error("cmd_deser: stb inside a command sequence");

endmodule

`default_nettype wire

//--- hdl/page_buf.sv
`default_nettype none

module page_buf #(
    parameter bit MEM_WRITES = 1'b1 // 1: memory writes, host reads
) (
    input  logic        mclk,
    input  logic        host_we,
    input  logic        host_re,
    input  logic [9:0]  host_addr,  // 9:8 page, 7:0 32-bit word
    input  logic [31:0] host_wdata,
    output logic [31:0] host_rdata, // one cycle after host_re
    input  logic [1:0]  page_in,
    input  logic        page_set,
    input  logic        page_next,
    input  logic        mem_we,
    input  logic        mem_re,
    input  logic [63:0] mem_wdata,
    output logic [63:0] mem_rdata   // one cycle after mem_re
);

    logic [31:0] mem_lo [512]; // even host words
    logic [31:0] mem_hi [512]; // odd host words
    logic [1:0]  page;
    logic [6:0]  cnt;          // memory-side word in page
    logic [8:0]  mem_idx;
    logic [8:0]  host_idx;

    assign mem_idx  = {page, cnt};
    assign host_idx = host_addr[9:1];

    always_ff @(posedge mclk) begin
        if (page_set) begin
            page <= page_in;
            cnt  <= 7'd0;
        end else if (page_next) begin
            page <= page + 2'd1;
            cnt  <= 7'd0;
        end else if (MEM_WRITES ? mem_we : mem_re) begin
            cnt <= cnt + 7'd1;
        end
    end

    if (MEM_WRITES) begin : g_mem_wr
        always_ff @(posedge mclk) begin
            if (mem_we) begin
                mem_lo[mem_idx] <= mem_wdata[31:0];
                mem_hi[mem_idx] <= mem_wdata[63:32];
            end
            if (host_re) begin
                host_rdata <= host_addr[0] ? mem_hi[host_idx] : mem_lo[host_idx];
            end
        end
        assign mem_rdata = 64'h0; // memory side only writes
    end else begin : g_mem_rd
        always_ff @(posedge mclk) begin
            if (host_we && host_addr[0]) begin
                mem_hi[host_idx] <= host_wdata;
            end
            if (host_we && !host_addr[0]) begin
                mem_lo[host_idx] <= host_wdata;
            end
            if (mem_re) begin
                mem_rdata <= {mem_hi[mem_idx], mem_lo[mem_idx]};
            end
        end
        assign host_rdata = 32'h0; // host side only writes
    end

endmodule

`default_nettype wire

//--- hdl/pio_config.svh
`ifndef PIO_CONFIG_SVH
`define PIO_CONFIG_SVH

// channel address decode, matched on the 16-bit command address
`define PIO_BASE_ADDR      16'h0100
`define PIO_ADDR_MASK      16'h03e0

// register indexes in address bits 4:0
`define PIO_REG_EN_RST     5'd0
`define PIO_REG_CMD        5'd1
`define PIO_REG_STATUS     5'd2

`define PIO_STATUS_ADDR    8'h02 // first byte of a status packet

`define PIO_CMD_DEPTH      4
`define PIO_PAGE_DEPTH     4
`define PIO_PAGE_CNT_BITS  4     // pending transfer counter width

`endif

//--- hdl/pio_pkg.sv
`default_nettype none

package pio_pkg;

    // one queued memory command, bit 14 down to bit 0
    typedef struct packed {
        logic       wait_done; // hold next command until this one completes
        logic       wr;        // memory write from the buffer
        logic       need;      // urgent request
        logic [1:0] page;      // buffer page
        logic [9:0] seq_addr;  // sequencer program address
    } cmd_word_t;

    // page record kept from grant until the transfer starts
    typedef struct packed {
        logic       wr;   // selects write buffer
        logic [1:0] page;
    } page_rec_t;

    // decoded register write from the serial command stream
    typedef struct packed {
        logic [4:0]  reg_idx;
        logic [31:0] data;
    } ser_cmd_t;

    // status bits sent in the packet payload
    typedef struct packed {
        logic half_full; // command fifo half full
        logic busy;      // queued, requesting or transfers pending
    } pio_status_t;

endpackage

`default_nettype wire

//--- hdl/pio_regs.sv
`default_nettype none
`include "pio_config.svh"

module pio_regs import pio_pkg::*; (
    input  logic       mclk,
    input  logic       mrst,
    input  logic       wr_stb,
    input  ser_cmd_t   wr,
    output logic       chn_rst,       // level, channel held in reset
    output logic       chn_en,        // requests allowed
    output logic       cmd_push,
    output cmd_word_t  cmd_word,
    input  logic       cmd_full,
    output logic       status_ctl_we,
    output logic [7:0] status_ctl
);

    logic [1:0] en_rst; // bit 0 run, bit 1 request enable
    logic       cmd_we;

    always_ff @(posedge mclk) begin
        if (mrst) begin
            en_rst <= 2'b00; // channel starts in reset
        end else if (wr_stb && (wr.reg_idx == `PIO_REG_EN_RST)) begin
            en_rst <= wr.data[1:0];
        end
    end

    assign chn_rst = ~en_rst[0];
    assign chn_en  = en_rst[1];

    assign cmd_we   = wr_stb && (wr.reg_idx == `PIO_REG_CMD);
    assign cmd_push = cmd_we && !cmd_full; // dropped when full
    assign cmd_word = cmd_word_t'(wr.data[14:0]);

    assign status_ctl_we = wr_stb && (wr.reg_idx == `PIO_REG_STATUS);
    assign status_ctl    = wr.data[7:0];

    // host overran the command queue, the command is lost
    assert property (@(posedge mclk) disable iff (mrst) cmd_we |-> !cmd_full)
        else $error("pio_regs: command dropped, fifo full");

endmodule

`default_nettype wire

//--- hdl/pio_sequencer.sv
`default_nettype none
`include "pio_config.svh"

module pio_sequencer import pio_pkg::*; (
    input  logic        mclk,
    input  logic        mrst,
    input  logic        chn_rst,
    input  logic        chn_en,
    input  cmd_word_t   cmd_head,
    input  logic        cmd_nempty,
    input  logic        cmd_half_full,
    output logic        cmd_pop,
    output logic        want_rq,
    output logic        need_rq,
    input  logic        channel_pgm_en, // grant pulse from arbiter
    input  logic        seq_done,
    output logic [9:0]  seq_data,
    output logic        seq_set,
    input  logic        buf_run,        // controller starts a transfer
    output logic [1:0]  rd_page,
    output logic [1:0]  wr_page,
    output logic        rd_page_set,
    output logic        wr_page_set,
    output pio_status_t status
);

    logic [`PIO_PAGE_CNT_BITS-1:0] pending; // granted, not yet done
    logic                          cmd_set;
    logic                          wait_r;
    logic                          active_r;
    logic                          short_busy;
    logic                          busy;
    logic                          start;
    page_rec_t                     page_new;
    page_rec_t                     page_head;
    logic [1:0]                    page_r;

    assign short_busy = want_rq || need_rq || cmd_set;
    assign busy       = short_busy || (pending != '0);
    assign start      = chn_en && !short_busy && cmd_nempty && ((pending == '0) || !wait_r);

    always_ff @(posedge mclk) begin
        if (mrst || chn_rst || channel_pgm_en) begin
            want_rq <= 1'b0;
            need_rq <= 1'b0;
        end else if (start) begin
            want_rq <= 1'b1;
            need_rq <= cmd_head.need;
        end

        if (mrst || chn_rst) begin
            cmd_set <= 1'b0;
            wait_r  <= 1'b0;
            pending <= '0;
        end else begin
            cmd_set <= channel_pgm_en; // hand-off one cycle after grant
            if (channel_pgm_en) begin
                wait_r <= cmd_head.wait_done;
            end
            if (cmd_set && !seq_done) begin
                pending <= pending + 1'b1;
            end else if (!cmd_set && seq_done) begin
                pending <= pending - 1'b1;
            end
        end

        if (mrst) begin
            active_r    <= 1'b0;
            rd_page_set <= 1'b0;
            wr_page_set <= 1'b0;
        end else begin
            active_r    <= cmd_nempty || busy; // page fifo kept only while in use
            rd_page_set <= buf_run && !page_head.wr;
            wr_page_set <= buf_run && page_head.wr;
        end
    end

    always_ff @(posedge mclk) begin
        if (buf_run) begin
            page_r <= page_head.page;
        end
    end

    assign seq_set  = cmd_set;
    assign cmd_pop  = cmd_set;
    assign seq_data = cmd_head.seq_addr;
    assign rd_page  = page_r;
    assign wr_page  = page_r;

    assign page_new.wr   = cmd_head.wr;
    assign page_new.page = cmd_head.page;

    assign status.half_full = cmd_half_full;
    assign status.busy      = cmd_nempty || busy;

    sync_fifo #(
        .payload_t (page_rec_t),
        .DEPTH     (`PIO_PAGE_DEPTH)
    ) page_fifo_i (
        .mclk      (mclk),
        .mrst      (mrst),
        .clr       (chn_rst || !active_r),
        .we        (channel_pgm_en), // record page at grant
        .din       (page_new),
        .re        (buf_run),
        .dout      (page_head),
        .nempty    (),
        .full      (),
        .half_full ()
    );

    // controller completions must match earlier hand-offs
    assert property (@(posedge mclk) disable iff (mrst || chn_rst) seq_done |-> (pending != '0))
        else $error("pio_sequencer: seq_done with nothing pending");

endmodule

`default_nettype wire

//--- hdl/pio_top.sv
`default_nettype none
`include "pio_config.svh"

module pio_top import pio_pkg::*; (
    input  logic        mclk,
    input  logic        mrst,
    input  logic [7:0]  cmd_ad,
    input  logic        cmd_stb,
    output logic [7:0]  status_ad,
    output logic        status_rq,
    input  logic        status_start,
    input  logic        port0_re,      // host read of the read buffer
    input  logic [9:0]  port0_addr,
    output logic [31:0] port0_data,
    input  logic        port1_we,      // host write of the write buffer
    input  logic [9:0]  port1_addr,
    input  logic [31:0] port1_data,
    output logic        want_rq,
    output logic        need_rq,
    input  logic        channel_pgm_en,
    output logic [9:0]  seq_data,
    output logic        seq_set,
    input  logic        seq_done,
    input  logic        buf_wr,
    input  logic        buf_wpage_nxt,
    input  logic        buf_run,
    input  logic [63:0] buf_wdata,
    input  logic        buf_rpage_nxt,
    input  logic        buf_rd,
    output logic [63:0] buf_rdata
);

    logic        wr_stb;
    ser_cmd_t    wr;
    logic        chn_rst;
    logic        chn_en;
    logic        cmd_push;
    cmd_word_t   cmd_word;
    cmd_word_t   cmd_head;
    logic        cmd_full;
    logic        cmd_nempty;
    logic        cmd_half_full;
    logic        cmd_pop;
    logic        status_ctl_we;
    logic [7:0]  status_ctl;
    logic [1:0]  rd_page;
    logic [1:0]  wr_page;
    logic        rd_page_set;
    logic        wr_page_set;
    pio_status_t status;

    cmd_deser cmd_deser_i (
        .mclk (mclk), .mrst (mrst), .ad (cmd_ad), .stb (cmd_stb),
        .wr_stb (wr_stb), .wr (wr)
    );

    pio_regs pio_regs_i (
        .mclk (mclk), .mrst (mrst), .wr_stb (wr_stb), .wr (wr),
        .chn_rst (chn_rst), .chn_en (chn_en),
        .cmd_push (cmd_push), .cmd_word (cmd_word), .cmd_full (cmd_full),
        .status_ctl_we (status_ctl_we), .status_ctl (status_ctl)
    );

    sync_fifo #(
        .payload_t (cmd_word_t),
        .DEPTH     (`PIO_CMD_DEPTH)
    ) cmd_fifo_i (
        .mclk (mclk), .mrst (mrst), .clr (chn_rst), // flushed while in reset
        .we (cmd_push), .din (cmd_word), .re (cmd_pop), .dout (cmd_head),
        .nempty (cmd_nempty), .full (cmd_full), .half_full (cmd_half_full)
    );

    pio_sequencer pio_sequencer_i (
        .mclk (mclk), .mrst (mrst), .chn_rst (chn_rst), .chn_en (chn_en),
        .cmd_head (cmd_head), .cmd_nempty (cmd_nempty),
        .cmd_half_full (cmd_half_full), .cmd_pop (cmd_pop),
        .want_rq (want_rq), .need_rq (need_rq),
        .channel_pgm_en (channel_pgm_en), .seq_done (seq_done),
        .seq_data (seq_data), .seq_set (seq_set), .buf_run (buf_run),
        .rd_page (rd_page), .wr_page (wr_page),
        .rd_page_set (rd_page_set), .wr_page_set (wr_page_set), .status (status)
    );

    status_gen status_gen_i (
        .mclk (mclk), .mrst (mrst), .ctl_we (status_ctl_we), .ctl (status_ctl),
        .status (status), .ad (status_ad), .rq (status_rq), .start (status_start)
    );

    // memory writes into this one, host reads it out
    page_buf #(.MEM_WRITES (1'b1)) chn0_buf_i (
        .mclk (mclk), .host_we (1'b0), .host_re (port0_re), .host_addr (port0_addr),
        .host_wdata (32'h0), .host_rdata (port0_data),
        .page_in (rd_page), .page_set (rd_page_set), .page_next (buf_wpage_nxt),
        .mem_we (buf_wr), .mem_re (1'b0), .mem_wdata (buf_wdata), .mem_rdata ()
    );

    // host fills this one, memory reads it
    page_buf #(.MEM_WRITES (1'b0)) chn1_buf_i (
        .mclk (mclk), .host_we (port1_we), .host_re (1'b0), .host_addr (port1_addr),
        .host_wdata (port1_data), .host_rdata (),
        .page_in (wr_page), .page_set (wr_page_set), .page_next (buf_rpage_nxt),
        .mem_we (1'b0), .mem_re (buf_rd), .mem_wdata (64'h0), .mem_rdata (buf_rdata)
    );

endmodule

`default_nettype wire

//--- hdl/status_gen.sv
`default_nettype none
`include "pio_config.svh"

module status_gen import pio_pkg::*; (
    input  logic        mclk,
    input  logic        mrst,
    input  logic        ctl_we,
    input  logic [7:0]  ctl,    // 7:6 mode, 5:0 sequence number
    input  pio_status_t status,
    output logic [7:0]  ad,
    output logic        rq,
    input  logic        start   // downstream took the address byte
);

    logic        on_change; // mode bit 7 resends on status change
    logic [5:0]  seq_num;
    pio_status_t status_d;
    logic        rq_r;
    logic        data_ph; // data byte on ad this cycle
    logic [7:0]  data_r;
    logic        changed;

    assign changed = status != status_d;

    always_ff @(posedge mclk) begin
        if (mrst) begin
            on_change <= 1'b0;
            seq_num   <= 6'd0;
            status_d  <= '0;
            rq_r      <= 1'b0;
            data_ph   <= 1'b0;
        end else begin
            if (ctl_we) begin
                on_change <= ctl[7];
                seq_num   <= ctl[5:0];
            end
            status_d <= status;
            data_ph  <= start;
            if ((ctl_we && ctl[6]) || (on_change && changed)) begin
                rq_r <= 1'b1; // new trigger beats start so another packet follows
            end else if (start) begin
                rq_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (start) begin
            data_r <= {seq_num, status}; // snapshot when the packet goes out
        end
    end

    assign rq = rq_r && !data_ph;
    assign ad = data_ph ? data_r : `PIO_STATUS_ADDR;

endmodule

`default_nettype wire

//--- hdl/sync_fifo.sv
`default_nettype none

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     mclk,
    input  logic     mrst,
    input  logic     clr,       // synchronous flush
    input  logic     we,
    input  payload_t din,
    input  logic     re,
    output payload_t dout,      // head word, fall-through
    output logic     nempty,
    output logic     full,
    output logic     half_full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t      mem [DEPTH];
    logic [AW-1:0] wptr;
    logic [AW-1:0] rptr;
    logic [AW:0]   count;

    always_ff @(posedge mclk) begin
        if (mrst || clr) begin // flush wins over push
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (we) begin
                wptr <= (wptr == AW'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (re) begin
                rptr <= (rptr == AW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            case ({we, re})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (we) begin
            mem[wptr] <= din;
        end
    end

    assign dout      = mem[rptr];
    assign nempty    = count != '0;
    assign full      = count == (AW+1)'(DEPTH);
    assign half_full = count >= (AW+1)'(DEPTH / 2);

    assert property (@(posedge mclk) disable iff (mrst || clr) re |-> nempty)
        else $error("sync_fifo: read while empty");
    assert property (@(posedge mclk) disable iff (mrst || clr) we |-> !full)
        else $error("sync_fifo: write while full");

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module pio_tb -f tb.f -o pio_sim
./obj_dir/pio_sim | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb.f
+incdir+hdl
hdl/pio_pkg.sv
hdl/cmd_deser.sv
hdl/pio_regs.sv
hdl/sync_fifo.sv
hdl/pio_sequencer.sv
hdl/status_gen.sv
hdl/page_buf.sv
hdl/pio_top.sv
tests/pio_tb.sv

//--- tests/pio_tb.sv
`default_nettype none
`include "pio_config.svh"

module pio_tb;

    localparam int SIG_WANT   = 0;
    localparam int SIG_STATUS = 1;
    localparam int WAIT_LIMIT = 200; // cycles before any wait gives up

    logic        mclk;
    logic        mrst;
    logic [7:0]  cmd_ad;
    logic        cmd_stb;
    logic [7:0]  status_ad;
    logic        status_rq;
    logic        status_start;
    logic        port0_re;
    logic [9:0]  port0_addr;
    logic [31:0] port0_data;
    logic        port1_we;
    logic [9:0]  port1_addr;
    logic [31:0] port1_data;
    logic        want_rq;
    logic        need_rq;
    logic        channel_pgm_en;
    logic [9:0]  seq_data;
    logic        seq_set;
    logic        seq_done;
    logic        buf_wr;
    logic        buf_wpage_nxt;
    logic        buf_run;
    logic [63:0] buf_wdata;
    logic        buf_rpage_nxt;
    logic        buf_rd;
    logic [63:0] buf_rdata;

    integer      seed = 32'hf600;
    logic [63:0] mem_words [4];  // controller side data for the read buffer
    logic [31:0] host_words [8]; // host side data for the write buffer

    pio_top pio_top_i (.*);

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        assert (got === exp)
            else fail_now($sformatf("MISMATCH at %0t: %s is %0h, expected %0h",
                                    $time, what, got, exp));
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge mclk);
    endtask

    // six bytes, AL AH D0..D3, stb with the first
    task automatic send_cmd(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] bytes;
        bytes = {data, addr};
        for (int i = 0; i < 6; i++) begin
            cmd_ad  = bytes[8*i +: 8];
            cmd_stb = (i == 0);
            @(negedge mclk);
        end
        cmd_stb = 1'b0;
        cmd_ad  = 8'h00;
        idle(2 + ($random(seed) & 3)); // write lands, random gap
    endtask

    task automatic reg_write(input logic [4:0] idx, input logic [31:0] data);
        send_cmd(`PIO_BASE_ADDR | {11'd0, idx}, data);
    endtask

    // wait, wr, need, page, sequencer address from bit 14 down
    function automatic logic [31:0] cmd_data(input logic wait_flag, input logic wr_flag,
                                             input logic need_flag, input logic [1:0] page,
                                             input logic [9:0] addr);
        return {17'd0, wait_flag, wr_flag, need_flag, page, addr};
    endfunction

    task automatic queue_cmd(input logic wait_flag, input logic wr_flag,
                             input logic need_flag, input logic [1:0] page,
                             input logic [9:0] addr);
        reg_write(`PIO_REG_CMD, cmd_data(wait_flag, wr_flag, need_flag, page, addr));
    endtask

    function automatic logic sig_value(input int sel);
        return (sel == SIG_WANT) ? want_rq : status_rq;
    endfunction

    task automatic wait_for(input int sel, input logic level, input string what);
        int cnt;
        cnt = 0;
        while ((sig_value(sel) !== level) && (cnt < WAIT_LIMIT)) begin
            @(negedge mclk);
            cnt++;
        end
        if (sig_value(sel) !== level) begin
            fail_now($sformatf("timeout while waiting for %s", what));
        end
    endtask

    // arbiter grant, then the hand-off one cycle later
    task automatic serve_request(input logic [9:0] addr, input logic need);
        wait_for(SIG_WANT, 1'b1, "want_rq to rise");
        check(need_rq, need, "need_rq");
        channel_pgm_en = 1'b1;
        @(negedge mclk);
        channel_pgm_en = 1'b0;
        check(seq_set, 1'b1, "seq_set after grant");
        check(seq_data, addr, "seq_data");
        @(negedge mclk);
        check(seq_set, 1'b0, "seq_set pulse width");
    endtask

    task automatic pulse_done;
        seq_done = 1'b1;
        @(negedge mclk);
        seq_done = 1'b0;
        idle(1);
    endtask

    task automatic expect_quiet(input int n);
        repeat (n) begin
            check(want_rq, 1'b0, "want_rq while quiet");
            check(need_rq, 1'b0, "need_rq while quiet");
            check(seq_set, 1'b0, "seq_set while quiet");
            check(status_rq, 1'b0, "status_rq while quiet");
            @(negedge mclk);
        end
    endtask

    task automatic start_transfer;
        buf_run = 1'b1;
        @(negedge mclk);
        buf_run = 1'b0;
        idle(2); // page reaches the buffer
    endtask

    assert property (@(posedge mclk) disable iff (mrst) seq_set |-> $past(channel_pgm_en))
        else fail_now("seq_set came without a grant on the cycle before");
    assert property (@(posedge mclk) disable iff (mrst) channel_pgm_en |=> !want_rq && !need_rq)
        else fail_now("request still high one cycle after the grant");

    initial begin
        mrst           = 1'b1;
        cmd_ad         = 8'h00;
        cmd_stb        = 1'b0;
        status_start   = 1'b0;
        port0_re       = 1'b0;
        port0_addr     = 10'd0;
        port1_we       = 1'b0;
        port1_addr     = 10'd0;
        port1_data     = 32'd0;
        channel_pgm_en = 1'b0;
        seq_done       = 1'b0;
        buf_wr         = 1'b0;
        buf_wpage_nxt  = 1'b0;
        buf_run        = 1'b0;
        buf_wdata      = 64'd0;
        buf_rpage_nxt  = 1'b0;
        buf_rd         = 1'b0;
        repeat (16) @(posedge mclk);
        @(negedge mclk);
        mrst = 1'b0;

        expect_quiet(8); // channel in reset
        reg_write(`PIO_REG_EN_RST, 32'h1); // running, requests off
        queue_cmd(1'b0, 1'b0, 1'b1, 2'd0, 10'h123);
        queue_cmd(1'b0, 1'b0, 1'b0, 2'd1, 10'h2a5);
        send_cmd(16'h0200 | {11'd0, `PIO_REG_CMD}, cmd_data(1'b0, 1'b0, 1'b1, 2'd0, 10'h3ff));
        expect_quiet(20);

        reg_write(`PIO_REG_STATUS, 32'h55); // mode 1, sequence 0x15
        wait_for(SIG_STATUS, 1'b1, "status_rq to rise");
        check(status_ad, `PIO_STATUS_ADDR, "status address byte");
        status_start = 1'b1;
        @(negedge mclk);
        status_start = 1'b0;
        check(status_rq, 1'b0, "status_rq in data phase");
        check(status_ad, {6'h15, 1'b1, 1'b1}, "status data byte"); // two queued, half full
        @(negedge mclk);
        check(status_rq, 1'b0, "status_rq after packet");

        reg_write(`PIO_REG_EN_RST, 32'h3);
        serve_request(10'h123, 1'b1);
        serve_request(10'h2a5, 1'b0);
        expect_quiet(20); // missed address queued nothing
        pulse_done();
        pulse_done();

        queue_cmd(1'b1, 1'b0, 1'b0, 2'd0, 10'h011); // waits for its own completion
        queue_cmd(1'b0, 1'b0, 1'b0, 2'd0, 10'h022);
        queue_cmd(1'b0, 1'b0, 1'b0, 2'd0, 10'h033);
        serve_request(10'h011, 1'b0);
        expect_quiet(12);
        pulse_done();
        serve_request(10'h022, 1'b0);
        serve_request(10'h033, 1'b0); // rises with 0x022 still pending
        pulse_done();
        pulse_done();

        for (int j = 0; j < 8; j++) begin
            host_words[j] = $random(seed);
            port1_addr    = {2'd1, 8'(j)};
            port1_data    = host_words[j];
            port1_we      = 1'b1;
            @(negedge mclk);
        end
        port1_we = 1'b0;
        queue_cmd(1'b0, 1'b0, 1'b0, 2'd2, 10'h101); // read, page 2
        queue_cmd(1'b0, 1'b1, 1'b0, 2'd1, 10'h202); // write, page 1
        serve_request(10'h101, 1'b0);
        serve_request(10'h202, 1'b0);

        start_transfer();
        for (int i = 0; i < 4; i++) begin
            mem_words[i] = {$random(seed), $random(seed)};
            buf_wdata    = mem_words[i];
            buf_wr       = 1'b1;
            @(negedge mclk);
        end
        buf_wr = 1'b0;
        for (int j = 0; j < 8; j++) begin
            port0_addr = {2'd2, 8'(j)};
            port0_re   = 1'b1;
            @(negedge mclk);
            port0_re = 1'b0;
            check(port0_data, (j % 2 == 1) ? mem_words[j / 2][63:32] : mem_words[j / 2][31:0],
                  "port0_data");
        end

        start_transfer();
        for (int i = 0; i < 4; i++) begin
            buf_rd = 1'b1;
            @(negedge mclk);
            buf_rd = 1'b0;
            check(buf_rdata, {host_words[2*i+1], host_words[2*i]}, "buf_rdata");
        end
        pulse_done();
        pulse_done();

        queue_cmd(1'b0, 1'b0, 1'b0, 2'd0, 10'h155);
        queue_cmd(1'b0, 1'b0, 1'b0, 2'd0, 10'h156);
        wait_for(SIG_WANT, 1'b1, "want_rq before disable");
        reg_write(`PIO_REG_EN_RST, 32'h0); // back into reset
        wait_for(SIG_WANT, 1'b0, "want_rq to drop in reset");
        reg_write(`PIO_REG_EN_RST, 32'h3);
        expect_quiet(20); // queue was flushed

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
